// ==== dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
// number of ways
`define DC_WAYS 4

// sets per way
`define DC_SETS 16

// dwords per 64-byte line, also the read burst length
`define DC_BEATS 8

// simulation memory
// depth in dwords, 32 KB
`define MEM_WORDS 4096

// cycles from the read address transfer to the first data beat
`define MEM_LAT 3

// added to the word index for the low half of the initial contents
`define MEM_SEED 32'h1234_0000

`endif

// ==== dcache_pkg.sv ====
package dcache_pkg;

	// byte address from the core, 32 bits
	typedef logic [31:0] addr_t;

	// core data word, also the width of the memory data bus
	typedef logic [63:0] dword_t;

	// one RAM row holds two dwords
	typedef logic [127:0] line_t;

	// tag field, addr[31:10]
	typedef logic [21:0] tag_t;

	// set index, addr[9:6]
	typedef logic [3:0] set_t;

	// RAM row address, set index plus row within the line
	typedef logic [5:0] ram_addr_t;

	// one bit per way
	typedef logic [3:0] way_oh_t;

	// byte strobe for one dword
	typedef logic [7:0] strb_t;

	// controller states
	typedef enum logic [1:0] {
		idle       = 2'b00,
		read_mem   = 2'b01,
		write_mem  = 2'b10,
		write_resp = 2'b11
	} cache_state_t;

endpackage

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_array import dcache_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  addr_t   addr,
	input  logic    fill_en,
	input  way_oh_t fill_way,
	output way_oh_t way_hit
);

	// fields of the request address
	set_t set_idx;
	tag_t req_tag;

	// tag storage per way and set
	tag_t tags [`DC_WAYS][`DC_SETS];

	// valid bits, one vector per way
	logic [`DC_SETS-1:0] vld [`DC_WAYS];

	assign set_idx = addr[9:6];
	assign req_tag = addr[31:10];

	// valid bits start clear, a fill marks the line present
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				vld[w] <= '0;
			end
		end else if (fill_en) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (fill_way[w]) begin
					vld[w][set_idx] <= 1'b1;
				end
			end
		end
	end

	// tag written together with the valid bit
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][set_idx] <= req_tag;
				end
			end
		end
	end

	// compare all ways of the selected set in parallel
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			way_hit[w] = vld[w][set_idx] && (tags[w][set_idx] == req_tag);
		end
	end

endmodule

// ==== dcache_way_ram.sv ====
`timescale 1ns/1ps

module dcache_way_ram import dcache_pkg::*; (
	input  logic      clk,
	input  logic      cen_n,
	input  logic      wen_n,
	input  line_t     bwen_n,
	input  ram_addr_t addr,
	input  line_t     din,
	output line_t     dout
);

	// one row per ram_addr_t value
	localparam int rows = 2 ** $bits(ram_addr_t);

	line_t mem [rows];

	// single port bank
	// enabled and writing updates the row, enabled and not writing reads it
	always_ff @(posedge clk) begin
		if (!cen_n) begin
			if (!wen_n) begin
				// keep bits whose bwen_n is high, take din where it is low
				mem[addr] <= (mem[addr] & bwen_n) | (din & ~bwen_n);
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      valid,
	output logic      ready,
	input  addr_t     addr,
	output dword_t    dout,
	input  logic      wren,
	input  dword_t    din,
	input  dword_t    mask,
	input  way_oh_t   way_hit,
	output logic      fill_en,
	output way_oh_t   fill_way,
	output way_oh_t   ram_cen_n,
	output logic      ram_wen_n,
	output line_t     ram_bwen_n,
	output line_t     ram_din,
	output ram_addr_t ram_addr,
	input  line_t     ram_dout0,
	input  line_t     ram_dout1,
	input  line_t     ram_dout2,
	input  line_t     ram_dout3,
	output addr_t     araddr,
	output logic      arvalid,
	input  logic      arready,
	input  dword_t    rdata,
	input  logic      rvalid,
	input  logic      rlast,
	output addr_t     awaddr,
	output logic      awvalid,
	input  logic      awready,
	output dword_t    wdata,
	output strb_t     wstrb,
	output logic      wvalid,
	input  logic      wready,
	input  logic      bvalid
);

	localparam int beat_w = $clog2(`DC_BEATS);

	cache_state_t      state;
	cache_state_t      state_nxt;
	way_oh_t           victim;
	logic [beat_w-1:0] beat;
	way_oh_t           hit_way_q;
	logic              half_q;
	logic              any_hit;
	logic              req_new;
	logic              rd_hit;
	logic              fill_beat;
	logic              aw_fire;
	line_t             line_sel;

	assign any_hit = |way_hit;
	// new request only in idle, valid is ignored during the ready pulse
	assign req_new = (state == idle) && valid && !ready;
	assign rd_hit = req_new && !wren && any_hit;
	assign fill_beat = (state == read_mem) && rvalid;
	assign aw_fire = awvalid && awready;

	// read miss asks for the whole line
	assign araddr = {addr[31:6], 6'b0};
	assign arvalid = req_new && !wren && !any_hit;

	// every write goes through as one beat
	assign awaddr = addr;
	assign awvalid = req_new && wren;
	assign wdata = din;
	assign wvalid = (state == write_mem);

	// byte strobe from the bit mask, one bit per byte lane
	always_comb begin
		for (int b = 0; b < $bits(strb_t); b++) begin
			wstrb[b] = mask[8*b];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	// a low ready on any channel keeps the current state
	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (arvalid && arready) begin
					state_nxt = read_mem;
				end else if (aw_fire) begin
					state_nxt = write_mem;
				end
			end
			read_mem: begin
				if (rvalid && rlast) begin
					state_nxt = idle;
				end
			end
			write_mem: begin
				if (wvalid && wready) begin
					state_nxt = write_resp;
				end
			end
			write_resp: begin
				if (bvalid) begin
					state_nxt = idle;
				end
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	// victim rotates while idle and holds through a fill
	// beat count picks the row and half for each fill beat
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= 4'b0001;
			beat <= '0;
		end else begin
			if (state == idle) begin
				victim <= {victim[2:0], victim[3]};
			end
			if (state != read_mem) begin
				beat <= '0;
			end else if (rvalid) begin
				beat <= beat + 1'b1;
			end
		end
	end

	// tag and valid follow the last beat
	assign fill_en = fill_beat && rlast;
	assign fill_way = victim;

	// RAM controls shared by all ways, enables per way
	always_comb begin
		if (state == read_mem) begin
			// fill, even beats go to the low half
			ram_cen_n = ~(victim & {4{rvalid}});
			ram_wen_n = !fill_beat;
			ram_addr = {addr[9:6], beat[beat_w-1:1]};
			ram_din = {rdata, rdata};
			ram_bwen_n = beat[0] ? {64'h0, {64{1'b1}}} : {{64{1'b1}}, 64'h0};
		end else begin
			// core path, write hit lands with the AW transfer
			ram_cen_n = ~(way_hit & {4{req_new}});
			ram_wen_n = !(aw_fire && any_hit);
			ram_addr = addr[9:4];
			ram_din = {din, din};
			ram_bwen_n = addr[3] ? {~mask, {64{1'b1}}} : {{64{1'b1}}, ~mask};
		end
	end

	// hit way kept for the cycle the RAM output is valid
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_way_q <= '0;
			ready <= 1'b0;
		end else begin
			hit_way_q <= rd_hit ? way_hit : '0;
			ready <= rd_hit || ((state == write_resp) && bvalid);
		end
	end

	// dword select held with the hit way
	always_ff @(posedge clk) begin
		if (rd_hit) begin
			half_q <= addr[3];
		end
	end

	always_comb begin
		case (hit_way_q)
			4'b0001: line_sel = ram_dout0;
			4'b0010: line_sel = ram_dout1;
			4'b0100: line_sel = ram_dout2;
			4'b1000: line_sel = ram_dout3;
			default: line_sel = '0;
		endcase
	end

	assign dout = half_q ? line_sel[127:64] : line_sel[63:0];

endmodule

// ==== axi_burst_mem.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module axi_burst_mem import dcache_pkg::*; #(
	parameter int WORDS = `MEM_WORDS,
	parameter int LAT   = `MEM_LAT
) (
	input  logic   clk,
	input  logic   rst,
	input  addr_t  araddr,
	input  logic   arvalid,
	output logic   arready,
	output dword_t rdata,
	output logic   rvalid,
	output logic   rlast,
	input  addr_t  awaddr,
	input  logic   awvalid,
	output logic   awready,
	input  dword_t wdata,
	input  strb_t  wstrb,
	input  logic   wvalid,
	output logic   wready,
	output logic   bvalid
);

	localparam int idx_w  = $clog2(WORDS);
	localparam int beat_w = $clog2(`DC_BEATS);
	localparam int lat_w  = $clog2(LAT + 2);

	dword_t            mem [WORDS];
	logic              rd_busy;
	logic [lat_w-1:0]  lat_cnt;
	logic [idx_w-1:0]  rd_idx;
	logic [beat_w-1:0] rd_beat;
	logic              aw_full;
	logic [idx_w-1:0]  aw_idx;
	logic [idx_w-1:0]  wr_idx;
	logic              ar_fire;
	logic              aw_fire;
	logic              w_fire;

	// one read burst at a time
	assign arready = !rd_busy;
	assign rvalid = rd_busy && (lat_cnt == '0);
	assign rlast = rvalid && (rd_beat == beat_w'(`DC_BEATS - 1));
	assign rdata = mem[rd_idx];

	// write side takes a new address until its data has been written
	assign awready = !aw_full && !bvalid;
	assign wready = !bvalid;

	assign ar_fire = arvalid && arready;
	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;

	// address and data in the same cycle use the incoming address
	assign wr_idx = aw_full ? aw_idx : awaddr[idx_w+2:3];

	// latency countdown, then one beat per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_busy <= 1'b0;
			lat_cnt <= '0;
			rd_beat <= '0;
		end else if (ar_fire) begin
			rd_busy <= 1'b1;
			lat_cnt <= lat_w'(LAT);
			rd_beat <= '0;
		end else if (rd_busy) begin
			if (lat_cnt != '0) begin
				lat_cnt <= lat_cnt - 1'b1;
			end else begin
				rd_beat <= rd_beat + 1'b1;
				if (rlast) begin
					rd_busy <= 1'b0;
				end
			end
		end
	end

	// word pointer walks the line
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_idx <= araddr[idx_w+2:3];
		end else if (rvalid) begin
			rd_idx <= rd_idx + 1'b1;
		end
	end

	// response one cycle after the data beat
	always_ff @(posedge clk) begin
		if (rst) begin
			aw_full <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			bvalid <= w_fire;
			if (w_fire) begin
				aw_full <= 1'b0;
			end else if (aw_fire) begin
				aw_full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			aw_idx <= awaddr[idx_w+2:3];
		end
	end

	// reset loads the known pattern, writes merge by strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < WORDS; k++) begin
				mem[k] <= {~32'(k), 32'(k) + `MEM_SEED};
			end
		end else if (w_fire) begin
			for (int b = 0; b < $bits(strb_t); b++) begin
				if (wstrb[b]) begin
					mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   valid,
	output logic   ready,
	input  addr_t  addr,
	output dword_t dout,
	input  logic   wren,
	input  dword_t din,
	input  dword_t mask
);

	// tag array
	way_oh_t   way_hit;
	logic      fill_en;
	way_oh_t   fill_way;

	// way RAMs
	way_oh_t   ram_cen_n;
	logic      ram_wen_n;
	line_t     ram_bwen_n;
	line_t     ram_din;
	ram_addr_t ram_addr;
	line_t     ram_dout0;
	line_t     ram_dout1;
	line_t     ram_dout2;
	line_t     ram_dout3;

	// memory channels
	addr_t     araddr;
	logic      arvalid;
	logic      arready;
	dword_t    rdata;
	logic      rvalid;
	logic      rlast;
	addr_t     awaddr;
	logic      awvalid;
	logic      awready;
	dword_t    wdata;
	strb_t     wstrb;
	logic      wvalid;
	logic      wready;
	logic      bvalid;

	dcache_tag_array u_tag_array (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.fill_en  (fill_en),
		.fill_way (fill_way),
		.way_hit  (way_hit)
	);

	dcache_way_ram u_way_ram0 (
		.clk    (clk),
		.cen_n  (ram_cen_n[0]),
		.wen_n  (ram_wen_n),
		.bwen_n (ram_bwen_n),
		.addr   (ram_addr),
		.din    (ram_din),
		.dout   (ram_dout0)
	);

	dcache_way_ram u_way_ram1 (
		.clk    (clk),
		.cen_n  (ram_cen_n[1]),
		.wen_n  (ram_wen_n),
		.bwen_n (ram_bwen_n),
		.addr   (ram_addr),
		.din    (ram_din),
		.dout   (ram_dout1)
	);

	dcache_way_ram u_way_ram2 (
		.clk    (clk),
		.cen_n  (ram_cen_n[2]),
		.wen_n  (ram_wen_n),
		.bwen_n (ram_bwen_n),
		.addr   (ram_addr),
		.din    (ram_din),
		.dout   (ram_dout2)
	);

	dcache_way_ram u_way_ram3 (
		.clk    (clk),
		.cen_n  (ram_cen_n[3]),
		.wen_n  (ram_wen_n),
		.bwen_n (ram_bwen_n),
		.addr   (ram_addr),
		.din    (ram_din),
		.dout   (ram_dout3)
	);

	dcache_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.valid      (valid),
		.ready      (ready),
		.addr       (addr),
		.dout       (dout),
		.wren       (wren),
		.din        (din),
		.mask       (mask),
		.way_hit    (way_hit),
		.fill_en    (fill_en),
		.fill_way   (fill_way),
		.ram_cen_n  (ram_cen_n),
		.ram_wen_n  (ram_wen_n),
		.ram_bwen_n (ram_bwen_n),
		.ram_din    (ram_din),
		.ram_addr   (ram_addr),
		.ram_dout0  (ram_dout0),
		.ram_dout1  (ram_dout1),
		.ram_dout2  (ram_dout2),
		.ram_dout3  (ram_dout3),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rlast      (rlast),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bvalid     (bvalid)
	);

	axi_burst_mem #(
		.WORDS (`MEM_WORDS),
		.LAT   (`MEM_LAT)
	) u_mem (
		.clk     (clk),
		.rst     (rst),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rlast   (rlast),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid)
	);

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

	localparam int timeout_cycles = 200;

	logic   clk;
	logic   rst;
	logic   valid;
	logic   ready;
	addr_t  addr;
	dword_t dout;
	logic   wren;
	dword_t din;
	dword_t mask;

	// shadow of the backing memory with the model's word indexing
	dword_t shadow [`MEM_WORDS];

	// expected value of the read in flight for the compare process
	logic   chk_read;
	dword_t chk_exp;

	int errors;
	int timeouts;
	int checks;
	int seed;

	dcache_top u_dcache_top (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.ready (ready),
		.addr  (addr),
		.dout  (dout),
		.wren  (wren),
		.din   (din),
		.mask  (mask)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// word index inside the 32 KB window
	function automatic int word_idx(input addr_t a);
		return int'(a[14:3]);
	endfunction

	// expected dword for a read of address a
	function automatic dword_t ref_dword(input addr_t a);
		return shadow[word_idx(a)];
	endfunction

	// byte strobe to 64-bit bit mask
	function automatic dword_t expand_strb(input strb_t s);
		dword_t m;
		for (int b = 0; b < 8; b++) begin
			m[8*b +: 8] = {8{s[b]}};
		end
		return m;
	endfunction

	// final counts and verdict
	task automatic end_run();
		$display("errors %0d, timeouts %0d, reads checked %0d", errors, timeouts, checks);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	// one core request driven on the falling edge
	// hit_exp asks for ready exactly one cycle after valid
	task automatic do_req(input addr_t a, input logic w, input dword_t d, input dword_t m,
			input logic hit_exp);
		int  cycles;
		logic done;
		int  idx;
		cycles = 0;
		done = 1'b0;
		idx = word_idx(a);
		@(negedge clk);
		addr = a;
		wren = w;
		din = d;
		mask = m;
		chk_read = !w;
		chk_exp = ref_dword(a);
		valid = 1'b1;
		// wait for the ready pulse or give up
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (ready || cycles >= timeout_cycles) begin
				done = 1'b1;
			end
		end
		valid = 1'b0;
		if (!ready) begin
			timeouts++;
			$display("no ready within %0d cycles for request at addr %h, time %0t",
				timeout_cycles, a, $time);
			end_run();
		end else begin
			if (hit_exp && cycles != 1) begin
				errors++;
				$display("** Error at %0t: ready latency expected 1 got %0d", $time, cycles);
			end
			// write lands in memory with only the enabled bytes
			if (w) begin
				shadow[idx] = (shadow[idx] & ~m) | (d & m);
			end
		end
	endtask

	task automatic read_req(input addr_t a, input logic hit_exp);
		do_req(a, 1'b0, '0, '0, hit_exp);
	endtask

	task automatic write_req(input addr_t a, input dword_t d, input dword_t m);
		do_req(a, 1'b1, d, m, 1'b0);
	endtask

	// compare on every read ready while dout is still held
	always @(posedge clk) begin
		if (!rst && ready && chk_read) begin
			checks++;
			if (dout !== chk_exp) begin
				errors++;
				$display("** Error at %0t: dout expected %h got %h", $time, chk_exp, dout);
			end
		end
	end

	initial begin
		addr_t  a;
		dword_t d;
		int     r;
		strb_t  s;
		clk = 1'b0;
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wren = 1'b0;
		din = '0;
		mask = '0;
		chk_read = 1'b0;
		chk_exp = '0;
		errors = 0;
		timeouts = 0;
		checks = 0;
		seed = 21;

		// initial memory contents by word index
		for (int k = 0; k < `MEM_WORDS; k++) begin
			shadow[k] = {~32'(k), 32'(k) + `MEM_SEED};
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// nothing should answer while the cache sits idle
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			if (ready) begin
				errors++;
				$display("** Error at %0t: ready expected 0 got %b", $time, ready);
			end
		end

		// cold read followed by the rest of the line as hits
		read_req(32'h8000_0100, 1'b0);
		for (int i = 1; i < `DC_BEATS; i++) begin
			read_req(32'h8000_0100 + 32'(8 * i), 1'b1);
		end

		// full write to a cached word
		write_req(32'h8000_0108, 64'hdead_beef_0bad_f00d, '1);
		read_req(32'h8000_0108, 1'b1);

		// partial writes to one cached and one uncached word
		write_req(32'h8000_0110, 64'h1111_2222_3333_4444, 64'h00ff_00ff_0000_ffff);
		read_req(32'h8000_0110, 1'b1);
		write_req(32'h8000_2018, 64'haaaa_bbbb_cccc_dddd, 64'hff00_0000_ff00_ff00);
		read_req(32'h8000_2018, 1'b0);
		read_req(32'h8000_2018, 1'b1);

		// six lines in set 5 force evictions in a 4-way set
		for (int pass = 0; pass < 2; pass++) begin
			for (int n = 0; n < 6; n++) begin
				read_req(32'h8000_0140 + 32'(n * 32'h400) + 32'(8 * n), 1'b0);
			end
		end

		// random mix inside the window
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			a = 32'h8000_0000 | (32'(r) & 32'h0000_7ff8);
			r = $random(seed);
			if (r[0]) begin
				s = r[15:8];
				d[63:32] = $random(seed);
				d[31:0] = $random(seed);
				write_req(a, d, expand_strb(s));
			end else begin
				read_req(a, 1'b0);
			end
		end

		repeat (2) @(negedge clk);
		end_run();
	end

endmodule

// ==== dcache.f ====
+incdir+.
dcache_pkg.sv
dcache_tag_array.sv
dcache_way_ram.sv
dcache_ctrl.sv
axi_burst_mem.sv
dcache_top.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f dcache.f --top-module tb_dcache \
	-Mdir obj_dir -o sim_dcache

./obj_dir/sim_dcache > sim.log
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi

echo "simulation passed"
